/* sources.f */
hdl/tlb_pkg.sv
hdl/tlb_entry_store.sv
hdl/tlb_walk_ctrl.sv
hdl/walk_beat_counter.sv
hdl/pte_line_assembler.sv
hdl/tlb_top.sv
test/tlb_checker.sv
test/tlb_tb.sv

/* Bender.yml */
package:
  name: tlb

sources:
  - files:
      - hdl/tlb_pkg.sv
      - hdl/tlb_entry_store.sv
      - hdl/tlb_walk_ctrl.sv
      - hdl/walk_beat_counter.sv
      - hdl/pte_line_assembler.sv
      - hdl/tlb_top.sv
  - target: test
    files:
      - test/tlb_checker.sv
      - test/tlb_tb.sv

/* test/tlb_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module tlb_tb;

	localparam int INDEX_BITS = 6;
	localparam int TAG_BITS = tlb_pkg::VA_BITS - tlb_pkg::PAGE_BITS
		- tlb_pkg::LINE_SEL_BITS - INDEX_BITS;
	localparam int LOOKUPS = 37;
	localparam int MAX_CYCLES = 200 * LOOKUPS;
	localparam logic [31:0] LFSR_MASK = 32'h8000_0057;

	logic clk;
	logic reset;
	logic flush;
	tlb_pkg::vaddr_t v_addr;
	tlb_pkg::paddr_t ptbr;
	logic abtr_grant;
	logic bus_reqack;
	logic bus_respcyc;
	tlb_pkg::pte_t bus_resp;
	tlb_pkg::paddr_t p_addr;
	tlb_pkg::status_t addr_available;
	logic abtr_reqcyc;
	logic bus_reqcyc;
	logic bus_respack;
	logic bus_busy;
	tlb_pkg::paddr_t bus_req;

	int error_count;
	int errors_before;
	int tests_run;
	int tests_failed;
	int cycles;
	int grant_hold;  // extra cycles the arbiter keeps the grant back
	logic [31:0] lfsr;
	logic [63:0] tag_a;
	logic [63:0] tag_t;
	logic [63:0] set_s;
	logic [63:0] set_e;
	logic [2:0] sel;
	logic [63:0] pool_tag [3];
	logic [63:0] pool_set [2];
	tlb_pkg::vaddr_t page_a;

	tlb_top #(
		.INDEX_BITS(INDEX_BITS)
	) u_tlb_top (
		.clk(clk), .reset(reset), .flush(flush), .v_addr(v_addr), .ptbr(ptbr),
		.abtr_grant(abtr_grant), .bus_reqack(bus_reqack), .bus_respcyc(bus_respcyc),
		.bus_resp(bus_resp), .p_addr(p_addr), .addr_available(addr_available),
		.abtr_reqcyc(abtr_reqcyc), .bus_reqcyc(bus_reqcyc), .bus_respack(bus_respack),
		.bus_busy(bus_busy), .bus_req(bus_req)
	);

	tlb_checker #(
		.INDEX_BITS(INDEX_BITS)
	) u_checker (
		.clk(clk), .reset(reset), .flush(flush), .v_addr(v_addr), .ptbr(ptbr),
		.abtr_grant(abtr_grant), .bus_reqack(bus_reqack), .bus_respcyc(bus_respcyc),
		.p_addr(p_addr), .addr_available(addr_available),
		.abtr_reqcyc(abtr_reqcyc), .bus_reqcyc(bus_reqcyc), .bus_respack(bus_respack),
		.bus_busy(bus_busy), .bus_req(bus_req), .error_count(error_count)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run still going after %0d cycles", cycles);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	function automatic logic next_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b)
			lfsr = lfsr ^ LFSR_MASK;
		return b;
	endfunction

	function automatic logic [63:0] rand_bits(int n);
		logic [63:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
			r = {r[62:0], next_bit()};
		return r;
	endfunction

	function automatic tlb_pkg::pte_t pte_value(tlb_pkg::paddr_t line_addr, int beat);
		return (line_addr + 64'(beat) * 64'd8) * 64'h9e37_79b9_7f4a_7c15;
	endfunction

	// tag, set and line selector with a random page offset
	function automatic tlb_pkg::vaddr_t make_va(logic [63:0] tag, logic [63:0] idx,
		logic [63:0] line_sel);
		return (tag << (15 + INDEX_BITS)) | (idx << 15) | (64'(line_sel[2:0]) << 12)
			| rand_bits(12);
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	// arbiter and memory side of one walk, entered in st_arb
	task automatic serve_walk();
		int gap;
		logic seen;
		tlb_pkg::paddr_t line_addr;
		gap = int'(rand_bits(2)) + grant_hold;
		repeat (gap) next_cycle();
		abtr_grant = 1'b1;
		seen = 1'b0;
		while (!seen) begin
			@(posedge clk);
			seen = bus_reqcyc;
			#1;
		end
		gap = int'(rand_bits(2));
		repeat (gap) next_cycle();
		bus_reqack = 1'b1;
		@(posedge clk);
		line_addr = bus_req;
		#1 bus_reqack = 1'b0;
		for (int i = 0; i < tlb_pkg::LINE_PTES; i++) begin
			gap = int'(rand_bits(2));
			repeat (gap) next_cycle();
			bus_respcyc = 1'b1;
			bus_resp = pte_value(line_addr, i);
			next_cycle();
			bus_respcyc = 1'b0;
		end
		next_cycle();  // fill cycle
		abtr_grant = 1'b0;
	endtask

	// hold v_addr until the translation hits
	task automatic lookup(tlb_pkg::vaddr_t va);
		logic hit;
		logic walk;
		v_addr = va;
		hit = 1'b0;
		while (!hit) begin
			@(posedge clk);
			hit = (addr_available == tlb_pkg::status_hit);
			walk = abtr_reqcyc && !abtr_grant;
			#1;
			if (walk)
				serve_walk();
		end
	endtask

	task automatic flush_pulse();
		flush = 1'b1;
		next_cycle();
		flush = 1'b0;
	endtask

	task automatic finish_test(string name);
		int errs;
		errs = error_count - errors_before;
		tests_run++;
		if (errs == 0) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errs);
			tests_failed++;
		end
		errors_before = error_count;
	endtask

	initial begin
		lfsr = 32'h1e469956;
		reset = 1'b1;
		flush = 1'b0;
		v_addr = '0;
		ptbr = '0;
		abtr_grant = 1'b0;
		bus_reqack = 1'b0;
		bus_respcyc = 1'b0;
		bus_resp = '0;
		grant_hold = 0;
		errors_before = 0;
		tests_run = 0;
		tests_failed = 0;
		repeat (5) @(posedge clk);
		#1 reset = 1'b0;
		ptbr = rand_bits(40) << 6;

		tag_a = rand_bits(TAG_BITS);
		set_s = rand_bits(INDEX_BITS);
		sel = 3'(rand_bits(3));
		page_a = make_va(tag_a, set_s, sel);
		lookup(page_a);
		finish_test("fresh page walk");

		lookup(make_va(tag_a, set_s, sel ^ 3'd5));
		finish_test("same line hit");

		tag_t = rand_bits(TAG_BITS);
		set_e = set_s ^ 64'd1;
		lookup(make_va(tag_t, set_e, rand_bits(3)));
		lookup(make_va(tag_t ^ 64'd1, set_e, rand_bits(3)));
		lookup(make_va(tag_t, set_e, rand_bits(3)));
		lookup(make_va(tag_t ^ 64'd2, set_e, rand_bits(3)));  // evicts tag_t ^ 1
		lookup(make_va(tag_t, set_e, rand_bits(3)));
		lookup(make_va(tag_t ^ 64'd2, set_e, rand_bits(3)));
		lookup(make_va(tag_t ^ 64'd1, set_e, rand_bits(3)));
		finish_test("lru eviction");

		lookup(page_a);
		flush_pulse();
		lookup(page_a);
		lookup(make_va(tag_t ^ 64'd2, set_e, rand_bits(3)));
		finish_test("flush");

		grant_hold = 12;
		lookup(make_va(tag_a ^ 64'd4, set_s, sel));
		grant_hold = 0;
		finish_test("grant withheld");

		for (int i = 0; i < 3; i++)
			pool_tag[i] = rand_bits(TAG_BITS);
		pool_set[0] = rand_bits(INDEX_BITS);
		pool_set[1] = pool_set[0] ^ 64'd2;
		for (int i = 0; i < 24; i++)
			lookup(make_va(pool_tag[rand_bits(2) % 3], pool_set[rand_bits(1)], rand_bits(3)));
		finish_test("random delays");

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
			error_count);
		if (tests_failed == 0 && error_count == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* test/tlb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tlb_checker #(
	parameter int INDEX_BITS = 6
) (
	input  wire                   clk,
	input  wire                   reset,
	input  wire                   flush,
	input  wire tlb_pkg::vaddr_t  v_addr,
	input  wire tlb_pkg::paddr_t  ptbr,
	input  wire                   abtr_grant,
	input  wire                   bus_reqack,
	input  wire                   bus_respcyc,
	input  wire tlb_pkg::paddr_t  p_addr,
	input  wire tlb_pkg::status_t addr_available,
	input  wire                   abtr_reqcyc,
	input  wire                   bus_reqcyc,
	input  wire                   bus_respack,
	input  wire                   bus_busy,
	input  wire tlb_pkg::paddr_t  bus_req,
	output int                    error_count
);

	localparam int SETS = 2 ** INDEX_BITS;
	localparam int TAG_LO = 15 + INDEX_BITS;

	logic [1:0] m_valid [SETS];
	logic [63:0] m_tag [2][SETS];
	logic [63:0] m_line [2][SETS];  // line address each entry was filled from
	logic m_lru [SETS];
	logic m_started;
	tlb_pkg::walk_state_t m_state;
	int m_beats;

	logic cap_way;
	int cap_idx;
	logic [63:0] cap_tag;
	logic [63:0] cap_line;

	int idx;
	logic [2:0] sel;
	logic [63:0] tag;
	logic hit0;
	logic hit1;
	logic idle;
	tlb_pkg::status_t exp_status;
	tlb_pkg::pte_t pte;
	tlb_pkg::paddr_t exp_paddr;

	// memory contents, same rule as the bus model
	function automatic tlb_pkg::pte_t pte_value(tlb_pkg::paddr_t line_addr, int beat);
		return (line_addr + 64'(beat) * 64'd8) * 64'h9e37_79b9_7f4a_7c15;
	endfunction

	// ptbr plus vpn with low three bits cleared, times 8
	function automatic tlb_pkg::paddr_t line_base(tlb_pkg::vaddr_t va, tlb_pkg::paddr_t base);
		logic [35:0] vpn;
		vpn = va[47:12];
		return base + 64'({vpn[35:3], 3'b000}) * 64'd8;
	endfunction

	task automatic report_value(string name, logic [63:0] got, logic [63:0] exp);
		if (got !== exp) begin
			$display("Error: %s is %0h, expected %0h at %0t", name, got, exp, $time);
			error_count++;
		end
	endtask

	initial error_count = 0;

	always @(posedge clk) begin
		idx = v_addr[15 +: INDEX_BITS];
		sel = v_addr[14:12];
		tag = {16'h0, v_addr[47:0]} >> TAG_LO;
		hit0 = m_valid[idx][0] && (m_tag[0][idx] == tag);
		hit1 = m_valid[idx][1] && (m_tag[1][idx] == tag);
		idle = (m_state == tlb_pkg::st_idle);
		if (!m_started)
			exp_status = tlb_pkg::status_idle;
		else if (!idle)
			exp_status = tlb_pkg::status_wait;
		else if (hit0 || hit1)
			exp_status = tlb_pkg::status_hit;
		else
			exp_status = tlb_pkg::status_miss;

		if (reset) begin
			m_started = 1'b0;
			m_state = tlb_pkg::st_idle;
			for (int s = 0; s < SETS; s++) begin
				m_valid[s] = 2'b00;
				m_lru[s] = 1'b0;
			end
		end else begin
			report_value("addr_available", addr_available, exp_status);
			if (exp_status == tlb_pkg::status_hit) begin
				pte = pte_value(m_line[hit1][idx], sel);
				exp_paddr = (64'(pte[63:10]) << 12) + 64'(v_addr[11:0]);
				report_value("p_addr", p_addr, exp_paddr);
			end else if (exp_status == tlb_pkg::status_miss) begin
				report_value("p_addr", p_addr, 64'd0);
			end
			report_value("abtr_reqcyc", abtr_reqcyc, !idle);
			report_value("bus_reqcyc", bus_reqcyc, m_state == tlb_pkg::st_req);
			report_value("bus_busy", bus_busy,
				(m_state == tlb_pkg::st_req) || (m_state == tlb_pkg::st_beats));
			report_value("bus_respack", bus_respack,
				(m_state == tlb_pkg::st_beats) && bus_respcyc);
			if (bus_reqcyc && !abtr_grant) begin
				$display("bus request raised while the arbiter grant is low at %0t", $time);
				error_count++;
			end
			if (m_state == tlb_pkg::st_req && bus_reqack)
				report_value("bus_req", bus_req, cap_line);

			m_started = 1'b1;
			if (exp_status == tlb_pkg::status_hit)
				m_lru[idx] = hit0;  // other way is next victim
			if (flush)
				for (int s = 0; s < SETS; s++)
					m_valid[s] = 2'b00;
			case (m_state)
				tlb_pkg::st_idle: begin
					if (exp_status == tlb_pkg::status_miss) begin
						cap_way = m_lru[idx];
						cap_idx = idx;
						cap_tag = tag;
						cap_line = line_base(v_addr, ptbr);
						m_state = tlb_pkg::st_arb;
					end
				end
				tlb_pkg::st_arb: begin
					if (abtr_grant)
						m_state = tlb_pkg::st_req;
				end
				tlb_pkg::st_req: begin
					if (bus_reqack) begin
						m_beats = 0;
						m_state = tlb_pkg::st_beats;
					end
				end
				tlb_pkg::st_beats: begin
					if (bus_respcyc)
						m_beats++;
					if (m_beats == tlb_pkg::LINE_PTES)
						m_state = tlb_pkg::st_fill;
				end
				default: begin  // fill
					m_valid[cap_idx][cap_way] = 1'b1;
					m_tag[cap_way][cap_idx] = cap_tag;
					m_line[cap_way][cap_idx] = cap_line;
					m_lru[cap_idx] = !cap_way;
					m_state = tlb_pkg::st_idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/tlb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tlb_top #(
	parameter int INDEX_BITS = 6
) (
	input  wire                   clk,
	input  wire                   reset,
	input  wire                   flush,
	input  wire tlb_pkg::vaddr_t  v_addr,
	input  wire tlb_pkg::paddr_t  ptbr,
	input  wire                   abtr_grant,
	input  wire                   bus_reqack,
	input  wire                   bus_respcyc,
	input  wire tlb_pkg::pte_t    bus_resp,
	output tlb_pkg::paddr_t       p_addr,
	output tlb_pkg::status_t      addr_available,
	output logic                  abtr_reqcyc,
	output logic                  bus_reqcyc,
	output logic                  bus_respack,
	output logic                  bus_busy,
	output tlb_pkg::paddr_t       bus_req
);

	localparam int LINE_LO = tlb_pkg::PAGE_BITS + tlb_pkg::LINE_SEL_BITS;
	localparam int LINE_SHIFT = tlb_pkg::LINE_SEL_BITS + 3;  // 8 bytes per pte

	logic lookup_miss;
	logic walk_busy;
	logic miss_capture;
	logic fill;
	logic beat_en;
	logic last_beat;
	tlb_pkg::pte_line_t line_data;
	tlb_pkg::paddr_t line_offset;

	// line-aligned vpn times pte size
	assign line_offset = tlb_pkg::paddr_t'(v_addr[tlb_pkg::VA_BITS-1:LINE_LO]) << LINE_SHIFT;
	assign bus_req = ptbr + line_offset;

	tlb_entry_store #(
		.INDEX_BITS(INDEX_BITS)
	) u_store (
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.v_addr(v_addr),
		.walk_busy(walk_busy),
		.miss_capture(miss_capture),
		.fill(fill),
		.line_data(line_data),
		.lookup_miss(lookup_miss),
		.addr_available(addr_available),
		.p_addr(p_addr)
	);

	tlb_walk_ctrl u_ctrl (
		.clk(clk),
		.reset(reset),
		.lookup_miss(lookup_miss),
		.abtr_grant(abtr_grant),
		.bus_reqack(bus_reqack),
		.bus_respcyc(bus_respcyc),
		.last_beat(last_beat),
		.walk_busy(walk_busy),
		.miss_capture(miss_capture),
		.fill(fill),
		.beat_en(beat_en),
		.abtr_reqcyc(abtr_reqcyc),
		.bus_reqcyc(bus_reqcyc),
		.bus_respack(bus_respack),
		.bus_busy(bus_busy)
	);

	walk_beat_counter u_beats (
		.clk(clk),
		.reset(reset),
		.beat_en(beat_en),
		.clear(miss_capture),  // restart count per walk
		.last_beat(last_beat)
	);

	pte_line_assembler u_line (
		.clk(clk),
		.beat_en(beat_en),
		.bus_resp(bus_resp),
		.line_data(line_data)
	);

endmodule

`default_nettype wire

/* hdl/pte_line_assembler.sv */
`timescale 1ns/1ps
`default_nettype none

module pte_line_assembler (
	input  wire                     clk,
	input  wire                     beat_en,
	input  wire tlb_pkg::pte_t      bus_resp,
	output tlb_pkg::pte_line_t      line_data
);

	localparam int LINE_BITS = tlb_pkg::LINE_PTES * tlb_pkg::PTE_BITS;

	tlb_pkg::pte_line_t line_q;

	// new beat enters at the top, first beat ends in pte 0
	always_ff @(posedge clk) begin
		if (beat_en)
			line_q <= {bus_resp, line_q[LINE_BITS-1:tlb_pkg::PTE_BITS]};
	end

	assign line_data = line_q;

endmodule

`default_nettype wire

/* hdl/walk_beat_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module walk_beat_counter (
	input  wire  clk,
	input  wire  reset,
	input  wire  beat_en,
	input  wire  clear,
	output logic last_beat
);

	logic [tlb_pkg::LINE_SEL_BITS-1:0] count;
	logic line_done;  // eighth beat seen since the last clear

	always_ff @(posedge clk) begin
		if (reset || clear)
			count <= '0;
		else if (beat_en)
			count <= count + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (reset || clear)
			line_done <= 1'b0;
		else if (last_beat)
			line_done <= 1'b1;
	end

	assign last_beat = beat_en && (count == tlb_pkg::LINE_SEL_BITS'(tlb_pkg::LINE_PTES - 1));

	// no extra beat gets taken once the line is complete
	a_no_beat_after_last: assert property (@(posedge clk) disable iff (reset)
		line_done |-> !beat_en);

endmodule

`default_nettype wire

/* hdl/tlb_walk_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tlb_walk_ctrl (
	input  wire  clk,
	input  wire  reset,
	input  wire  lookup_miss,
	input  wire  abtr_grant,
	input  wire  bus_reqack,
	input  wire  bus_respcyc,
	input  wire  last_beat,
	output logic walk_busy,
	output logic miss_capture,
	output logic fill,
	output logic beat_en,
	output logic abtr_reqcyc,
	output logic bus_reqcyc,
	output logic bus_respack,
	output logic bus_busy
);

	tlb_pkg::walk_state_t state;
	tlb_pkg::walk_state_t state_next;

	always_ff @(posedge clk) begin
		if (reset)
			state <= tlb_pkg::st_idle;
		else
			state <= state_next;
	end

	always_comb begin
		state_next = state;
		case (state)
			tlb_pkg::st_idle: begin
				if (lookup_miss)
					state_next = tlb_pkg::st_arb;
			end
			tlb_pkg::st_arb: begin
				if (abtr_grant)
					state_next = tlb_pkg::st_req;
			end
			tlb_pkg::st_req: begin
				if (bus_reqack)  // request dropped next cycle
					state_next = tlb_pkg::st_beats;
			end
			tlb_pkg::st_beats: begin
				if (beat_en && last_beat)
					state_next = tlb_pkg::st_fill;
			end
			tlb_pkg::st_fill: begin
				state_next = tlb_pkg::st_idle;
			end
			default: begin
				state_next = tlb_pkg::st_idle;
			end
		endcase
	end

	assign walk_busy = (state != tlb_pkg::st_idle);
	assign miss_capture = (state == tlb_pkg::st_idle) && lookup_miss;
	assign fill = (state == tlb_pkg::st_fill);

	// every beat presented during st_beats is taken
	assign beat_en = (state == tlb_pkg::st_beats) && bus_respcyc;
	assign bus_respack = beat_en;

	assign abtr_reqcyc = (state != tlb_pkg::st_idle);  // arb through fill
	assign bus_reqcyc = (state == tlb_pkg::st_req);
	assign bus_busy = (state == tlb_pkg::st_req) || (state == tlb_pkg::st_beats);

	// the bus is only driven while the arbiter grants it
	a_req_granted: assert property (@(posedge clk) disable iff (reset)
		bus_reqcyc |-> abtr_grant);

endmodule

`default_nettype wire

/* hdl/tlb_entry_store.sv */
`timescale 1ns/1ps
`default_nettype none

module tlb_entry_store #(
	parameter int INDEX_BITS = 6
) (
	input  wire                        clk,
	input  wire                        reset,
	input  wire                        flush,
	input  wire tlb_pkg::vaddr_t       v_addr,
	input  wire                        walk_busy,
	input  wire                        miss_capture,
	input  wire                        fill,
	input  wire tlb_pkg::pte_line_t    line_data,
	output logic                       lookup_miss,
	output tlb_pkg::status_t           addr_available,
	output tlb_pkg::paddr_t            p_addr
);

	localparam int IDX_LO   = tlb_pkg::PAGE_BITS + tlb_pkg::LINE_SEL_BITS;
	localparam int TAG_LO   = IDX_LO + INDEX_BITS;
	localparam int TAG_BITS = tlb_pkg::VA_BITS - TAG_LO;
	localparam int SETS     = 2 ** INDEX_BITS;

	logic [tlb_pkg::LINE_SEL_BITS-1:0] line_sel;
	logic [INDEX_BITS-1:0] index;
	logic [TAG_BITS-1:0] tag;

	logic [TAG_BITS-1:0] tag_mem [2][SETS];
	tlb_pkg::pte_line_t line_mem [2][SETS];
	logic [SETS-1:0] valid [2];
	logic [SETS-1:0] lru;  // way to replace next, per set
	logic started;

	logic [1:0] way_hit;
	logic hit_way;
	logic hit_now;
	tlb_pkg::pte_t hit_pte;

	logic victim_way;
	logic [INDEX_BITS-1:0] index_q;
	logic [TAG_BITS-1:0] tag_q;

	always_comb begin
		line_sel = v_addr[IDX_LO-1:tlb_pkg::PAGE_BITS];
		index = v_addr[IDX_LO +: INDEX_BITS];
		tag = v_addr[tlb_pkg::VA_BITS-1:TAG_LO];
		for (int w = 0; w < 2; w++) begin
			way_hit[w] = valid[w][index] && (tag_mem[w][index] == tag);
		end
		hit_way = way_hit[1];
		hit_pte = line_mem[hit_way][index][line_sel*tlb_pkg::PTE_BITS +: tlb_pkg::PTE_BITS];
		hit_now = started && !walk_busy && (way_hit != 2'b00);
		lookup_miss = started && !walk_busy && (way_hit == 2'b00);
	end

	always_comb begin
		if (!started)
			addr_available = tlb_pkg::status_idle;
		else if (walk_busy)
			addr_available = tlb_pkg::status_wait;
		else if (hit_now)
			addr_available = tlb_pkg::status_hit;
		else
			addr_available = tlb_pkg::status_miss;
	end

	// ppn shifted up to the page boundary, offset below it
	assign p_addr = hit_now ?
		(tlb_pkg::paddr_t'(hit_pte[63:10]) << tlb_pkg::PAGE_BITS)
		+ tlb_pkg::paddr_t'(v_addr[tlb_pkg::PAGE_BITS-1:0]) : '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			started <= 1'b0;
			valid[0] <= '0;
			valid[1] <= '0;
			lru <= '0;
		end else begin
			started <= 1'b1;
			if (hit_now)
				lru[index] <= ~hit_way;  // other way becomes lru
			if (flush) begin
				valid[0] <= '0;
				valid[1] <= '0;
			end
			if (fill) begin  // after flush so a fill in the same cycle stays
				valid[victim_way][index_q] <= 1'b1;
				lru[index_q] <= ~victim_way;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (miss_capture) begin
			victim_way <= lru[index];
			index_q <= index;
			tag_q <= tag;
		end
		if (fill) begin
			tag_mem[victim_way][index_q] <= tag_q;
			line_mem[victim_way][index_q] <= line_data;
		end
	end

	// a fill never leaves a second copy of a resident tag
	a_single_way_hit: assert property (@(posedge clk) disable iff (reset)
		!(way_hit[0] && way_hit[1]));

endmodule

`default_nettype wire

/* hdl/tlb_pkg.sv */
`default_nettype none

package tlb_pkg;

	localparam int PAGE_BITS     = 12;  // page offset
	localparam int LINE_PTES     = 8;   // ptes per page-table line
	localparam int LINE_SEL_BITS = 3;
	localparam int VA_BITS       = 48;  // translated part of v_addr
	localparam int PTE_BITS      = 64;

	typedef logic [63:0] vaddr_t;
	typedef logic [63:0] paddr_t;
	typedef logic [PTE_BITS-1:0] pte_t;  // ppn in 63:10
	typedef logic [LINE_PTES*PTE_BITS-1:0] pte_line_t;

	// lookup status on addr_available
	typedef logic [1:0] status_t;

	localparam status_t status_idle = 2'd0;  // only after reset
	localparam status_t status_wait = 2'd1;
	localparam status_t status_hit  = 2'd2;
	localparam status_t status_miss = 2'd3;

	typedef enum logic [2:0] {
		st_idle,
		st_arb,    // waiting for grant
		st_req,    // line read on the bus
		st_beats,  // collecting response beats
		st_fill    // line written into the store
	} walk_state_t;

endpackage

`default_nettype wire
